// ==== hdl/cpu_macros.svh ====
// ====================
// cpu configuration: external address width,
// register count and first fetch address
// ====================
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// address bits kept on both outer ports
`define CPU_AW 24

// number of general registers, sets the index width
`define CPU_NREGS 16

// address of the first instruction fetch
`define CPU_RESET_PC 32'h0000_0000

`endif

// ==== hdl/cpu_pkg.sv ====
// ====================
// cpu types: opcodes, instruction formats,
// decoded control and data bus request
// ====================
`include "cpu_macros.svh"

package cpu_pkg;

  typedef logic [$clog2(`CPU_NREGS)-1:0] reg_idx_t;

  typedef enum logic [3:0] {
    OP_ADD  = 4'h0,
    OP_SUB  = 4'h1,
    OP_AND  = 4'h2,
    OP_OR   = 4'h3,
    OP_XOR  = 4'h4,
    OP_ADDI = 4'h5,
    OP_LW   = 4'h6,
    OP_SW   = 4'h7,
    OP_SB   = 4'h8,
    OP_BEQ  = 4'h9,
    OP_JMP  = 4'hA,
    OP_HALT = 4'hF
  } opcode_e;

  // register-register view
  typedef struct packed {
    opcode_e     opcode;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic [15:0] pad;
  } r_fmt_t;

  // immediate view, rd doubles as source for stores and BEQ
  typedef struct packed {
    opcode_e     opcode;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    logic [3:0]  pad;
    logic [15:0] imm;
  } i_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
  } instr_u;

  typedef struct packed {
    opcode_e     opcode;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic [31:0] imm;
    logic        reg_we;
    logic        mem_rd;
    logic        mem_wr;
    logic        byte_st;
    logic        branch;
  } ctrl_t;

  typedef struct packed {
    logic        we;
    logic [3:0]  sel;
    logic [31:0] adr;
    logic [31:0] dat;
  } bus_req_t;

endpackage

// ==== hdl/cpu_decode.sv ====
// ====================
// instruction decoder: picks the instruction
// format and sets control fields and flags
// ====================
module cpu_decode (
  input  cpu_pkg::instr_u instr_i,
  output cpu_pkg::ctrl_t  ctrl_o
);

  logic [31:0] imm_sext;

  assign imm_sext = {{16{instr_i.i_fmt.imm[15]}}, instr_i.i_fmt.imm};

  always_comb begin
    ctrl_o = '0;
    ctrl_o.opcode = instr_i.r_fmt.opcode;
    case (instr_i.r_fmt.opcode)
      cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND,
      cpu_pkg::OP_OR, cpu_pkg::OP_XOR: begin
        ctrl_o.rd     = instr_i.r_fmt.rd;
        ctrl_o.rs1    = instr_i.r_fmt.rs1;
        ctrl_o.rs2    = instr_i.r_fmt.rs2;
        ctrl_o.reg_we = 1'b1;
      end
      cpu_pkg::OP_ADDI, cpu_pkg::OP_LW: begin
        ctrl_o.rd     = instr_i.i_fmt.rd;
        ctrl_o.rs1    = instr_i.i_fmt.rs1;
        ctrl_o.imm    = imm_sext;
        ctrl_o.reg_we = 1'b1;
        ctrl_o.mem_rd = (instr_i.i_fmt.opcode == cpu_pkg::OP_LW);
      end
      // store data comes from the rd field
      cpu_pkg::OP_SW, cpu_pkg::OP_SB: begin
        ctrl_o.rs1     = instr_i.i_fmt.rs1;
        ctrl_o.rs2     = instr_i.i_fmt.rd;
        ctrl_o.imm     = imm_sext;
        ctrl_o.mem_wr  = 1'b1;
        ctrl_o.byte_st = (instr_i.i_fmt.opcode == cpu_pkg::OP_SB);
      end
      // compares rs1 against the rd field
      cpu_pkg::OP_BEQ: begin
        ctrl_o.rs1    = instr_i.i_fmt.rs1;
        ctrl_o.rs2    = instr_i.i_fmt.rd;
        ctrl_o.imm    = imm_sext;
        ctrl_o.branch = 1'b1;
      end
      cpu_pkg::OP_JMP: begin
        ctrl_o.imm    = imm_sext;
        ctrl_o.branch = 1'b1;
      end
      // HALT and any unassigned opcode
      default: begin
        ctrl_o.opcode = cpu_pkg::OP_HALT;
      end
    endcase
  end

endmodule

// ==== hdl/cpu_regfile.sv ====
// ====================
// register file, 2 read ports, 1 write port
// ====================
`include "cpu_macros.svh"

module cpu_regfile (
  input  logic              clk,
  input  cpu_pkg::reg_idx_t rs1_i,
  input  cpu_pkg::reg_idx_t rs2_i,
  input  cpu_pkg::reg_idx_t rd_i,
  input  logic              we_i,
  input  logic [31:0]       wdata_i,
  output logic [31:0]       rdata1_o,
  output logic [31:0]       rdata2_o
);

  logic [31:0] regs [`CPU_NREGS];

  // r0 is never written
  always_ff @(posedge clk) begin
    if (we_i && (rd_i != '0)) begin
      regs[rd_i] <= wdata_i;
    end
  end

  // r0 forced to zero on read
  assign rdata1_o = (rs1_i == '0) ? 32'h0 : regs[rs1_i];
  assign rdata2_o = (rs2_i == '0) ? 32'h0 : regs[rs2_i];

endmodule

// ==== hdl/cpu_core.sv ====
// ====================
// cpu core: fetch/execute FSM, ALU, branches
// and one bus transaction at a time
// ====================
`include "cpu_macros.svh"

module cpu_core (
  input  logic              clk,
  input  logic              rst_i,
  // instruction port
  output logic              icpu_cs_o,
  output logic [31:0]       icpu_adr_o,
  input  logic [31:0]       icpu_dat_r_i,
  input  logic              icpu_ack_i,
  // data port
  output logic              dcpu_cs_o,
  output cpu_pkg::bus_req_t dcpu_req_o,
  input  logic [31:0]       dcpu_dat_r_i,
  input  logic              dcpu_ack_i,
  // register file
  output cpu_pkg::reg_idx_t rf_rs1_o,
  output cpu_pkg::reg_idx_t rf_rs2_o,
  output cpu_pkg::reg_idx_t rf_rd_o,
  output logic              rf_we_o,
  output logic [31:0]       rf_wdata_o,
  input  logic [31:0]       rf_rdata1_i,
  input  logic [31:0]       rf_rdata2_i,
  output logic              halted_o
);

  typedef enum logic [1:0] {
    ST_FETCH,
    ST_EXEC,
    ST_MEM,
    ST_HALTED
  } state_e;

  state_e          state_q;
  logic [31:0]     pc_q;
  logic            icpu_cs_q;
  logic            dcpu_cs_q;
  cpu_pkg::instr_u ir_q;
  logic [31:0]     ld_data_q;

  cpu_pkg::instr_u fetched;
  cpu_pkg::ctrl_t  ctrl;
  logic            fetched_is_mem;
  logic [31:0]     alu_res;
  logic [31:0]     mem_adr;
  logic [31:0]     br_target;
  logic            br_taken;
  logic [31:0]     pc_next;

  cpu_decode u_decode (
    .instr_i (ir_q),
    .ctrl_o  (ctrl)
  );

  // peek at the opcode during the fetch ack
  assign fetched = icpu_dat_r_i;
  assign fetched_is_mem = fetched.r_fmt.opcode inside
                          {cpu_pkg::OP_LW, cpu_pkg::OP_SW, cpu_pkg::OP_SB};

  always_comb begin
    case (ctrl.opcode)
      cpu_pkg::OP_ADD:  alu_res = rf_rdata1_i + rf_rdata2_i;
      cpu_pkg::OP_SUB:  alu_res = rf_rdata1_i - rf_rdata2_i;
      cpu_pkg::OP_AND:  alu_res = rf_rdata1_i & rf_rdata2_i;
      cpu_pkg::OP_OR:   alu_res = rf_rdata1_i | rf_rdata2_i;
      cpu_pkg::OP_XOR:  alu_res = rf_rdata1_i ^ rf_rdata2_i;
      cpu_pkg::OP_ADDI: alu_res = rf_rdata1_i + ctrl.imm;
      default:          alu_res = 32'h0;
    endcase
  end

  // target is relative to the next instruction, in words
  assign br_target = pc_q + 32'd4 + {ctrl.imm[29:0], 2'b00};
  assign br_taken  = ctrl.branch &&
                     ((ctrl.opcode == cpu_pkg::OP_JMP) || (rf_rdata1_i == rf_rdata2_i));
  assign pc_next   = br_taken ? br_target : pc_q + 32'd4;

  // data request, stable while in MEM since ir and registers hold
  assign mem_adr = rf_rdata1_i + ctrl.imm;

  always_comb begin
    dcpu_req_o.we  = ctrl.mem_wr;
    dcpu_req_o.adr = mem_adr;
    if (ctrl.byte_st) begin
      dcpu_req_o.sel = 4'b0001 << mem_adr[1:0];
      dcpu_req_o.dat = {4{rf_rdata2_i[7:0]}};
    end else begin
      dcpu_req_o.sel = 4'b1111;
      dcpu_req_o.dat = rf_rdata2_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q   <= ST_FETCH;
      pc_q      <= `CPU_RESET_PC;
      icpu_cs_q <= 1'b0;
      dcpu_cs_q <= 1'b0;
    end else begin
      case (state_q)
        ST_FETCH: begin
          // first fetch after reset
          if (!icpu_cs_q) begin
            icpu_cs_q <= 1'b1;
          end else if (icpu_ack_i) begin
            icpu_cs_q <= 1'b0;
            if (fetched_is_mem) begin
              dcpu_cs_q <= 1'b1;
              state_q   <= ST_MEM;
            end else begin
              state_q <= ST_EXEC;
            end
          end
        end
        ST_MEM: begin
          if (dcpu_ack_i) begin
            dcpu_cs_q <= 1'b0;
            state_q   <= ST_EXEC;
          end
        end
        ST_EXEC: begin
          if (ctrl.opcode == cpu_pkg::OP_HALT) begin
            state_q <= ST_HALTED;
          end else begin
            pc_q      <= pc_next;
            icpu_cs_q <= 1'b1;
            state_q   <= ST_FETCH;
          end
        end
        default: begin
          state_q <= ST_HALTED;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state_q == ST_FETCH) && icpu_cs_q && icpu_ack_i) begin
      ir_q <= fetched;
    end
    if ((state_q == ST_MEM) && dcpu_ack_i) begin
      ld_data_q <= dcpu_dat_r_i;
    end
  end

  assign icpu_cs_o  = icpu_cs_q;
  assign icpu_adr_o = pc_q;
  assign dcpu_cs_o  = dcpu_cs_q;

  // writeback happens in EXEC only
  assign rf_rs1_o   = ctrl.rs1;
  assign rf_rs2_o   = ctrl.rs2;
  assign rf_rd_o    = ctrl.rd;
  assign rf_we_o    = (state_q == ST_EXEC) && ctrl.reg_we;
  // loads write back the captured bus word
  assign rf_wdata_o = ctrl.mem_rd ? ld_data_q : alu_res;

  assign halted_o = (state_q == ST_HALTED);

endmodule

// ==== hdl/cpu_top_wrapper.sv ====
// ====================
// cpu top: core plus register file,
// both bus addresses cut to AW bits
// ====================
`include "cpu_macros.svh"

module cpu_top_wrapper #(
  parameter int AW = `CPU_AW
) (
  input  logic          clk,
  input  logic          rst_i,
  // instruction bus
  output logic          icpu_cs_o,
  output logic [AW-1:0] icpu_adr_o,
  input  logic [31:0]   icpu_dat_r_i,
  input  logic          icpu_ack_i,
  // data bus
  output logic          dcpu_cs_o,
  output logic          dcpu_we_o,
  output logic [3:0]    dcpu_sel_o,
  output logic [AW-1:0] dcpu_adr_o,
  output logic [31:0]   dcpu_dat_w_o,
  input  logic [31:0]   dcpu_dat_r_i,
  input  logic          dcpu_ack_i,
  output logic          halted_o
);

  logic [31:0]       iadr;
  cpu_pkg::bus_req_t dreq;
  cpu_pkg::reg_idx_t rf_rs1;
  cpu_pkg::reg_idx_t rf_rs2;
  cpu_pkg::reg_idx_t rf_rd;
  logic              rf_we;
  logic [31:0]       rf_wdata;
  logic [31:0]       rf_rdata1;
  logic [31:0]       rf_rdata2;

  cpu_core u_core (
    .clk          (clk),
    .rst_i        (rst_i),
    .icpu_cs_o    (icpu_cs_o),
    .icpu_adr_o   (iadr),
    .icpu_dat_r_i (icpu_dat_r_i),
    .icpu_ack_i   (icpu_ack_i),
    .dcpu_cs_o    (dcpu_cs_o),
    .dcpu_req_o   (dreq),
    .dcpu_dat_r_i (dcpu_dat_r_i),
    .dcpu_ack_i   (dcpu_ack_i),
    .rf_rs1_o     (rf_rs1),
    .rf_rs2_o     (rf_rs2),
    .rf_rd_o      (rf_rd),
    .rf_we_o      (rf_we),
    .rf_wdata_o   (rf_wdata),
    .rf_rdata1_i  (rf_rdata1),
    .rf_rdata2_i  (rf_rdata2),
    .halted_o     (halted_o)
  );

  cpu_regfile u_regfile (
    .clk      (clk),
    .rs1_i    (rf_rs1),
    .rs2_i    (rf_rs2),
    .rd_i     (rf_rd),
    .we_i     (rf_we),
    .wdata_i  (rf_wdata),
    .rdata1_o (rf_rdata1),
    .rdata2_o (rf_rdata2)
  );

  // keep only the low AW address bits
  assign icpu_adr_o   = iadr[AW-1:0];
  assign dcpu_adr_o   = dreq.adr[AW-1:0];
  assign dcpu_we_o    = dreq.we;
  assign dcpu_sel_o   = dreq.sel;
  assign dcpu_dat_w_o = dreq.dat;

endmodule

// ==== tests/cpu_properties.sv ====
// ====================
// bus protocol assertions for the cpu top
// ====================
`include "cpu_macros.svh"

module cpu_properties #(
  parameter int AW = `CPU_AW
) (
  input logic          clk,
  input logic          rst_i,
  input logic          icpu_cs_o,
  input logic [AW-1:0] icpu_adr_o,
  input logic          icpu_ack_i,
  input logic          dcpu_cs_o,
  input logic          dcpu_we_o,
  input logic [3:0]    dcpu_sel_o,
  input logic [AW-1:0] dcpu_adr_o,
  input logic [31:0]   dcpu_dat_w_o,
  input logic          dcpu_ack_i,
  input logic          halted_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // watched by the testbench
  int fault_count = 0;

  ireq_stable: assert property (@(posedge clk) disable iff (rst_i)
    icpu_cs_o && !icpu_ack_i |=> icpu_cs_o && $stable(icpu_adr_o))
    else begin
      $error("instruction request changed before ack");
      fault_count++;
    end

  dreq_stable: assert property (@(posedge clk) disable iff (rst_i)
    dcpu_cs_o && !dcpu_ack_i |=> dcpu_cs_o && $stable(dcpu_we_o) &&
      $stable(dcpu_sel_o) && $stable(dcpu_adr_o) && $stable(dcpu_dat_w_o))
    else begin
      $error("data request changed before ack");
      fault_count++;
    end

  one_port: assert property (@(posedge clk) disable iff (rst_i)
    !(icpu_cs_o && dcpu_cs_o))
    else begin
      $error("both ports selected together");
      fault_count++;
    end

  // no reset term here, reset is the trigger
  idle_after_reset: assert property (@(posedge clk)
    rst_i |=> !icpu_cs_o && !dcpu_cs_o)
    else begin
      $error("chip select high right after reset");
      fault_count++;
    end

  quiet_when_halted: assert property (@(posedge clk) disable iff (rst_i)
    halted_o |=> !$rose(icpu_cs_o) && !$rose(dcpu_cs_o))
    else begin
      $error("bus request after halt");
      fault_count++;
    end

endmodule

bind cpu_top_wrapper cpu_properties #(.AW(AW)) u_props (
  .clk          (clk),
  .rst_i        (rst_i),
  .icpu_cs_o    (icpu_cs_o),
  .icpu_adr_o   (icpu_adr_o),
  .icpu_ack_i   (icpu_ack_i),
  .dcpu_cs_o    (dcpu_cs_o),
  .dcpu_we_o    (dcpu_we_o),
  .dcpu_sel_o   (dcpu_sel_o),
  .dcpu_adr_o   (dcpu_adr_o),
  .dcpu_dat_w_o (dcpu_dat_w_o),
  .dcpu_ack_i   (dcpu_ack_i),
  .halted_o     (halted_o)
);

// ==== tests/cpu_tb.sv ====
// ====================
// cpu testbench: memory models, program table
// and expected stores
// ====================
`include "cpu_macros.svh"

module cpu_tb #(
  parameter int SEED = 90
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int PROG_LEN     = 36;
  localparam int NUM_STORES   = 13;
  localparam int NUM_FETCHES  = 33;
  localparam int HALT_TIMEOUT = 2000;
  localparam int QUIET_CYCLES = 20;

  // operands as ADDI immediates, sign-extended
  localparam logic [15:0] IMM_A    = 16'h1234;
  localparam logic [15:0] IMM_B    = 16'hF0F1;
  localparam logic [15:0] IMM_BASE = 16'hF000;
  localparam logic [31:0] OP_A     = {{16{IMM_A[15]}}, IMM_A};
  localparam logic [31:0] OP_B     = {{16{IMM_B[15]}}, IMM_B};
  // data base has high bits set so the address cut shows
  localparam logic [31:0] BASE     = {{16{IMM_BASE[15]}}, IMM_BASE};
  localparam logic [7:0]  BYTE0    = 8'hAB;

  typedef struct packed {
    logic [31:0] adr;
    logic [3:0]  sel;
    logic [31:0] dat;
  } store_t;

  logic                clk;
  logic                rst;
  logic                icpu_cs;
  logic [`CPU_AW-1:0]  icpu_adr;
  logic [31:0]         icpu_dat_r;
  logic                icpu_ack;
  logic                dcpu_cs;
  logic                dcpu_we;
  logic [3:0]          dcpu_sel;
  logic [`CPU_AW-1:0]  dcpu_adr;
  logic [31:0]         dcpu_dat_w;
  logic [31:0]         dcpu_dat_r;
  logic                dcpu_ack;
  logic                halted;

  logic [31:0] prog [PROG_LEN];
  store_t      exp_stores [NUM_STORES];
  int          fetch_path [NUM_FETCHES];
  logic [31:0] imem [64];
  logic [31:0] dmem [64];
  int          store_count;
  int          fetch_count;

  cpu_top_wrapper uut (
    .clk          (clk),
    .rst_i        (rst),
    .icpu_cs_o    (icpu_cs),
    .icpu_adr_o   (icpu_adr),
    .icpu_dat_r_i (icpu_dat_r),
    .icpu_ack_i   (icpu_ack),
    .dcpu_cs_o    (dcpu_cs),
    .dcpu_we_o    (dcpu_we),
    .dcpu_sel_o   (dcpu_sel),
    .dcpu_adr_o   (dcpu_adr),
    .dcpu_dat_w_o (dcpu_dat_w),
    .dcpu_dat_r_i (dcpu_dat_r),
    .dcpu_ack_i   (dcpu_ack),
    .halted_o     (halted)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] encode_instr(input cpu_pkg::opcode_e op,
      input logic [3:0] rd, input logic [3:0] rs1, input logic [3:0] rs2,
      input logic [15:0] imm);
    return {op, rd, rs1, rs2, imm};
  endfunction

  // preload pattern, every word differs
  function automatic logic [31:0] fill_word(input logic [5:0] idx);
    return 32'hD00D_0000 ^ {4{idx, 2'b00}};
  endfunction

  function automatic logic [5:0] mem_index(input logic [31:0] adr);
    return adr[7:2];
  endfunction

  function automatic store_t make_store(input logic [31:0] adr, input logic [3:0] sel,
      input logic [31:0] dat);
    store_t st;
    st.adr = adr;
    st.sel = sel;
    st.dat = dat;
    return st;
  endfunction

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display(">>> FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
      input logic [31:0] expected);
    if (got !== expected) begin
      fail_run($sformatf("Error: %s is 0x%08h, expected 0x%08h", name, got, expected));
    end
  endtask

  task automatic build_program();
    prog[0]  = encode_instr(cpu_pkg::OP_ADDI, 4'd1, 4'd0, 4'd0, IMM_A);
    prog[1]  = encode_instr(cpu_pkg::OP_ADDI, 4'd2, 4'd0, 4'd0, IMM_B);
    prog[2]  = encode_instr(cpu_pkg::OP_ADDI, 4'd3, 4'd0, 4'd0, IMM_BASE);
    prog[3]  = encode_instr(cpu_pkg::OP_ADD,  4'd4, 4'd1, 4'd2, 16'h0);
    prog[4]  = encode_instr(cpu_pkg::OP_SW,   4'd4, 4'd3, 4'd0, 16'd0);
    prog[5]  = encode_instr(cpu_pkg::OP_SUB,  4'd4, 4'd1, 4'd2, 16'h0);
    prog[6]  = encode_instr(cpu_pkg::OP_SW,   4'd4, 4'd3, 4'd0, 16'd4);
    prog[7]  = encode_instr(cpu_pkg::OP_AND,  4'd4, 4'd1, 4'd2, 16'h0);
    prog[8]  = encode_instr(cpu_pkg::OP_SW,   4'd4, 4'd3, 4'd0, 16'd8);
    prog[9]  = encode_instr(cpu_pkg::OP_OR,   4'd4, 4'd1, 4'd2, 16'h0);
    prog[10] = encode_instr(cpu_pkg::OP_SW,   4'd4, 4'd3, 4'd0, 16'd12);
    prog[11] = encode_instr(cpu_pkg::OP_XOR,  4'd4, 4'd1, 4'd2, 16'h0);
    prog[12] = encode_instr(cpu_pkg::OP_SW,   4'd4, 4'd3, 4'd0, 16'd16);
    prog[13] = encode_instr(cpu_pkg::OP_LW,   4'd5, 4'd3, 4'd0, 16'd32);
    prog[14] = encode_instr(cpu_pkg::OP_ADDI, 4'd5, 4'd5, 4'd0, 16'h0011);
    prog[15] = encode_instr(cpu_pkg::OP_SW,   4'd5, 4'd3, 4'd0, 16'd20);
    prog[16] = encode_instr(cpu_pkg::OP_LW,   4'd6, 4'd3, 4'd0, 16'd36);
    prog[17] = encode_instr(cpu_pkg::OP_ADDI, 4'd6, 4'd6, 4'd0, 16'hFFFF);
    prog[18] = encode_instr(cpu_pkg::OP_SW,   4'd6, 4'd3, 4'd0, 16'd24);
    prog[19] = encode_instr(cpu_pkg::OP_ADDI, 4'd7, 4'd0, 4'd0, {8'h3C, BYTE0});
    prog[20] = encode_instr(cpu_pkg::OP_SB,   4'd7, 4'd3, 4'd0, 16'd48);
    prog[21] = encode_instr(cpu_pkg::OP_ADDI, 4'd7, 4'd7, 4'd0, 16'd1);
    prog[22] = encode_instr(cpu_pkg::OP_SB,   4'd7, 4'd3, 4'd0, 16'd49);
    prog[23] = encode_instr(cpu_pkg::OP_ADDI, 4'd7, 4'd7, 4'd0, 16'd1);
    prog[24] = encode_instr(cpu_pkg::OP_SB,   4'd7, 4'd3, 4'd0, 16'd50);
    prog[25] = encode_instr(cpu_pkg::OP_ADDI, 4'd7, 4'd7, 4'd0, 16'd1);
    prog[26] = encode_instr(cpu_pkg::OP_SB,   4'd7, 4'd3, 4'd0, 16'd51);
    // taken branch skips word 28
    prog[27] = encode_instr(cpu_pkg::OP_BEQ,  4'd1, 4'd1, 4'd0, 16'd1);
    prog[28] = encode_instr(cpu_pkg::OP_SW,   4'd1, 4'd3, 4'd0, 16'd60);
    // r1 and r2 differ, falls through
    prog[29] = encode_instr(cpu_pkg::OP_BEQ,  4'd2, 4'd1, 4'd0, 16'd5);
    prog[30] = encode_instr(cpu_pkg::OP_SW,   4'd1, 4'd3, 4'd0, 16'd56);
    prog[31] = encode_instr(cpu_pkg::OP_JMP,  4'd0, 4'd0, 4'd0, 16'd1);
    prog[32] = encode_instr(cpu_pkg::OP_SW,   4'd2, 4'd3, 4'd0, 16'd60);
    prog[33] = encode_instr(cpu_pkg::OP_SW,   4'd2, 4'd3, 4'd0, 16'd52);
    prog[34] = encode_instr(cpu_pkg::OP_HALT, 4'd0, 4'd0, 4'd0, 16'h0);
    prog[35] = encode_instr(cpu_pkg::OP_SW,   4'd1, 4'd3, 4'd0, 16'd60);
  endtask

  task automatic build_expected();
    int i;
    exp_stores[0]  = make_store(BASE + 32'd0,  4'hF, OP_A + OP_B);
    exp_stores[1]  = make_store(BASE + 32'd4,  4'hF, OP_A - OP_B);
    exp_stores[2]  = make_store(BASE + 32'd8,  4'hF, OP_A & OP_B);
    exp_stores[3]  = make_store(BASE + 32'd12, 4'hF, OP_A | OP_B);
    exp_stores[4]  = make_store(BASE + 32'd16, 4'hF, OP_A ^ OP_B);
    exp_stores[5]  = make_store(BASE + 32'd20, 4'hF,
                                fill_word(mem_index(BASE + 32'd32)) + 32'h11);
    exp_stores[6]  = make_store(BASE + 32'd24, 4'hF,
                                fill_word(mem_index(BASE + 32'd36)) - 32'd1);
    exp_stores[7]  = make_store(BASE + 32'd48, 4'b0001, {4{BYTE0}});
    exp_stores[8]  = make_store(BASE + 32'd49, 4'b0010, {4{8'(BYTE0 + 8'd1)}});
    exp_stores[9]  = make_store(BASE + 32'd50, 4'b0100, {4{8'(BYTE0 + 8'd2)}});
    exp_stores[10] = make_store(BASE + 32'd51, 4'b1000, {4{8'(BYTE0 + 8'd3)}});
    exp_stores[11] = make_store(BASE + 32'd56, 4'hF, OP_A);
    exp_stores[12] = make_store(BASE + 32'd52, 4'hF, OP_B);
    // straight run up to the first branch, then the branch and jump targets
    for (i = 0; i < 28; i++) begin
      fetch_path[i] = i;
    end
    fetch_path[28] = 29;
    fetch_path[29] = 30;
    fetch_path[30] = 31;
    fetch_path[31] = 33;
    fetch_path[32] = 34;
  endtask

  task automatic check_fetch();
    logic [31:0] exp_adr;
    if (fetch_count >= NUM_FETCHES) begin
      fail_run($sformatf("unexpected extra fetch from address 0x%08h", 32'(icpu_adr)));
    end else begin
      exp_adr = `CPU_RESET_PC + 32'(fetch_path[fetch_count]) * 32'd4;
      check_value("icpu_adr_o", 32'(icpu_adr), 32'(exp_adr[`CPU_AW-1:0]));
      fetch_count++;
    end
  endtask

  task automatic record_store();
    store_t exp_st;
    int     lane;
    if (store_count >= NUM_STORES) begin
      fail_run($sformatf("unexpected extra store to address 0x%08h", 32'(dcpu_adr)));
    end else begin
      exp_st = exp_stores[store_count];
      check_value("dcpu_adr_o", 32'(dcpu_adr), 32'(exp_st.adr[`CPU_AW-1:0]));
      check_value("dcpu_sel_o", 32'(dcpu_sel), 32'(exp_st.sel));
      check_value("dcpu_dat_w_o", dcpu_dat_w, exp_st.dat);
      for (lane = 0; lane < 4; lane++) begin
        if (dcpu_sel[lane]) begin
          dmem[dcpu_adr[7:2]][lane*8 +: 8] = dcpu_dat_w[lane*8 +: 8];
        end
      end
      store_count++;
    end
  endtask

  // instruction memory, ack after 0 to 3 idle cycles
  always begin
    @(posedge clk);
    #1;
    icpu_ack = 1'b0;
    if (icpu_cs) begin
      repeat ($urandom_range(3, 0)) begin
        @(posedge clk);
        #1;
      end
      check_fetch();
      icpu_dat_r = imem[icpu_adr[7:2]];
      icpu_ack = 1'b1;
    end
  end

  // data memory, writes are checked as they land
  always begin
    @(posedge clk);
    #1;
    dcpu_ack = 1'b0;
    if (dcpu_cs) begin
      repeat ($urandom_range(3, 0)) begin
        @(posedge clk);
        #1;
      end
      if (dcpu_we) begin
        record_store();
      end else begin
        dcpu_dat_r = dmem[dcpu_adr[7:2]];
      end
      dcpu_ack = 1'b1;
    end
  end

  always @(negedge clk) begin
    if (uut.u_props.fault_count != 0) begin
      fail_run("a bus protocol assertion failed");
    end
  end

  initial begin
    int i;
    int waited;
    void'($urandom(SEED));
    clk = 1'b0;
    rst = 1'b1;
    icpu_ack = 1'b0;
    icpu_dat_r = 32'h0;
    dcpu_ack = 1'b0;
    dcpu_dat_r = 32'h0;
    store_count = 0;
    fetch_count = 0;
    build_program();
    build_expected();
    // unused words hold HALT with the index in the immediate
    for (i = 0; i < 64; i++) begin
      imem[i] = (i < PROG_LEN) ? prog[i] :
                encode_instr(cpu_pkg::OP_HALT, 4'd0, 4'd0, 4'd0, 16'(i));
      dmem[i] = fill_word(6'(i));
    end

    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    waited = 0;
    while (!halted && waited < HALT_TIMEOUT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!halted) begin
      fail_run("timeout while waiting for halted_o to rise");
    end

    // after HALT the buses must stay idle
    for (waited = 0; waited < QUIET_CYCLES; waited++) begin
      @(posedge clk);
      #1;
      if (icpu_cs || dcpu_cs) begin
        fail_run("a bus request appeared after HALT");
      end
      if (!halted) begin
        fail_run("halted_o dropped after HALT");
      end
    end

    check_value("fetch_count", 32'(fetch_count), 32'(NUM_FETCHES));
    if (store_count != NUM_STORES) begin
      check_value("store_count", 32'(store_count), 32'(NUM_STORES));
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

// ==== filelist.f ====
+incdir+hdl
hdl/cpu_pkg.sv
hdl/cpu_decode.sv
hdl/cpu_regfile.sv
hdl/cpu_core.sv
hdl/cpu_top_wrapper.sv
tests/cpu_properties.sv
tests/cpu_tb.sv

// ==== Makefile ====
# Verilator flow for the cpu testbench

VERILATOR ?= verilator
TOP       ?= cpu_tb
SEED      ?= 90
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
ERR_LIMIT ?= 100

VFLAGS ?= --timing --assert -f $(FILELIST) --top-module $(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS)

build:
	$(VERILATOR) --binary $(VFLAGS) -GSEED=$(SEED) --Mdir $(OBJ_DIR)

# assertion errors are counted by the testbench, which ends the run
sim: build
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+$(ERR_LIMIT)

clean:
	rm -rf $(OBJ_DIR)
